//--- common/fir_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fir_ctrl_if;
    import fir_pkg::*;

    // one-cycle pulse, regs to engine
    logic start;
    // block length, held by regs
    len_t data_len;
    // engine out of idle
    logic busy;
    // one-cycle pulse on the last output handshake
    logic done;

    modport regs (
        output start,
        output data_len,
        input  busy,
        input  done
    );

    modport engine (
        input  start,
        input  data_len,
        output busy,
        output done
    );

endinterface

`default_nettype wire

//--- common/fir_pkg.sv
`default_nettype none

package fir_pkg;

    // bus and sample widths
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 12;
    localparam int NUM_TAPS = 11;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    // taps and ring slots, 0 to 10
    typedef logic [3:0]        tap_idx_t;
    typedef logic [31:0]       len_t;

    // AXI-Lite register map
    localparam addr_t ADDR_AP_CTRL   = 12'h000;
    localparam addr_t ADDR_DATA_LEN  = 12'h010;
    // coefficient k at base + 4k
    localparam addr_t ADDR_COEF_BASE = 12'h020;

    // ap_ctrl bit positions
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;
    // idle only
    localparam data_t AP_CTRL_RESET = 32'h0000_0004;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_IN,
        ST_MAC,
        ST_WAIT_OUT
    } fir_state_e;

endpackage

`default_nettype wire

//--- common/fir_tap_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fir_tap_if;
    import fir_pkg::*;

    // write port, from the AXI-Lite side
    logic     wr_en;
    tap_idx_t wr_idx;
    data_t    wr_data;
    // readback port for the AXI-Lite side
    tap_idx_t rd_idx_cfg;
    data_t    rd_data_cfg;
    // tap walk port for the MAC
    tap_idx_t rd_idx_mac;
    data_t    rd_data_mac;

    modport cfg (
        output wr_en, wr_idx, wr_data, rd_idx_cfg,
        input  rd_data_cfg
    );

    modport mac (
        output rd_idx_mac,
        input  rd_data_mac
    );

    modport ram (
        input  wr_en, wr_idx, wr_data, rd_idx_cfg, rd_idx_mac,
        output rd_data_cfg, rd_data_mac
    );

endinterface

`default_nettype wire

//--- dv/fir_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module fir_asserts (
    input logic           axis_clk,
    input logic           axis_rst_n,
    input logic           awready,
    input logic           ap_idle,
    input logic           ss_tready,
    input logic           sm_tvalid,
    input logic           sm_tready,
    input logic           sm_tlast,
    input fir_pkg::data_t sm_tdata
);

    // stalled output beat holds
    a_sm_hold: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    ) else $error("sm beat changed while stalled");

    // one sample in flight
    a_one_in_flight: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid)
    ) else $error("ss_tready high while an output waits");

    // writes only while idle
    a_write_idle: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        $rose(awready) |-> ap_idle
    ) else $error("awready rose while not idle");

endmodule

bind fir_top fir_asserts u_asserts (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awready    (awready),
    .ap_idle    (u_regs.ap_idle),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tlast   (sm_tlast),
    .sm_tdata   (sm_tdata)
);

`default_nettype wire

//--- dv/fir_stimulus.txt
# C: tap index and coefficient, M: the same but written while the next block runs
# B: block length, then one X line per sample with input and expected output, all hex
C 0 00000001
C 1 ffffffff
C 2 00000002
C 3 00000000
C 4 00000003
C 5 00000000
C 6 00000000
C 7 00000001
C 8 00000000
C 9 00000000
C a 00000002
B 0000000c
X 00000001 00000001
X 00000002 00000001
X 00000003 00000003
X 00000004 00000005
X 00000005 0000000a
X 00000006 0000000f
X 00000007 00000014
X 00000008 0000001a
X 00000009 00000020
X 0000000a 00000026
X 0000000b 0000002e
X 0000000c 00000036
B 00000003
X 80000000 80000000
X 00000003 80000003
X 7fffffff 7ffffffc
M 0 00000005
B 00000004
X 0000000a 0000000a
X 00000014 0000000a
X 0000001e 0000001e
X 00000028 00000032
B 00000002
X 00000001 00000005
X 00000002 00000009

//--- dv/tb_fir.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fir;
    import fir_pkg::*;

    localparam int CLK_HALF    = 4;
    localparam int TIMEOUT     = 200;
    // a whole block under back-pressure
    localparam int RUN_TIMEOUT = 4000;
    localparam int SEED        = 32'h0b9f7e94;

    logic  axis_clk;
    logic  axis_rst_n;
    logic  awvalid;
    addr_t awaddr;
    logic  awready;
    logic  wvalid;
    data_t wdata;
    logic  wready;
    logic  arvalid;
    addr_t araddr;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    logic  rready;
    logic  ss_tvalid;
    data_t ss_tdata;
    logic  ss_tlast;
    logic  ss_tready;
    logic  sm_tvalid;
    data_t sm_tdata;
    logic  sm_tlast;
    logic  sm_tready;

    // samples and expected outputs of the current block
    data_t x_q[$];
    data_t y_q[$];
    // h0 as last written
    data_t h0;
    int    block_num;
    logic  block_over;
    // coefficient write issued while the next block runs
    logic  held_pending;
    int    held_idx;
    data_t held_val;

    fir_top UUT (.*);

    always #CLK_HALF axis_clk = ~axis_clk;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input data_t got, input data_t expected);
        assert (got === expected) else begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                        $time, what, got, expected));
        end
    endtask

    task automatic report_timeout(input string what);
        stop_with_failure($sformatf("timeout at %0t ns while waiting for %s", $time, what));
    endtask

    function automatic addr_t coef_addr(input int k);
        return ADDR_COEF_BASE + addr_t'(4 * k);
    endfunction

    // aw and w held together until awready and wready rise on the same edge
    task automatic axil_write(input addr_t addr, input data_t data, input int limit);
        int n;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
            assert (wready === awready) else begin
                stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time,
                                            "wready and awready differ"));
            end
        end while (!awready && n < limit);
        if (!awready) begin
            report_timeout("the AXI-Lite write handshake");
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, output data_t val);
        int n;
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!arready && n < TIMEOUT);
        if (!arready) begin
            report_timeout("arready");
        end
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!rvalid && n < TIMEOUT);
        if (!rvalid) begin
            report_timeout("rvalid");
        end
        val = rdata;
        rready <= 1'b0;
    endtask

    task automatic send_sample(input data_t x, input logic last);
        int n;
        ss_tdata  <= x;
        ss_tlast  <= last;
        ss_tvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!ss_tready && n < TIMEOUT);
        if (!ss_tready) begin
            report_timeout("ss_tready");
        end
        ss_tvalid <= 1'b0;
        ss_tlast  <= 1'b0;
    endtask

    // random sm_tready every cycle until a beat is taken
    task automatic receive_output(output data_t y, output logic last);
        int   n;
        logic fire;
        n = 0;
        do begin
            @(posedge axis_clk);
            fire = sm_tvalid && sm_tready;
            sm_tready <= 1'($urandom);
            n++;
        end while (!fire && n < TIMEOUT);
        if (!fire) begin
            report_timeout("an output beat");
        end
        y    = sm_tdata;
        last = sm_tlast;
    endtask

    task automatic run_block(input len_t len);
        data_t got;
        logic  last;
        axil_write(ADDR_DATA_LEN, len, TIMEOUT);
        axil_read(ADDR_DATA_LEN, got);
        check_value("data length", got, len);
        axil_write(ADDR_AP_CTRL, 32'h1, TIMEOUT);
        for (int i = 0; i < int'(len); i++) begin
            send_sample(x_q[i], i == int'(len) - 1);
            receive_output(got, last);
            check_value($sformatf("output %0d of block %0d", i, block_num), got, y_q[i]);
            check_value("sm_tlast", data_t'(last), data_t'(i == int'(len) - 1));
            // history must be zero after a restart
            if (i == 0 && block_num > 0) begin
                check_value("first output after restart", got, h0 * x_q[0]);
            end
        end
        block_over = 1'b1;
        // done and idle first, then idle only once done was read
        axil_read(ADDR_AP_CTRL, got);
        check_value("ap_ctrl after the block", got, 32'h6);
        axil_read(ADDR_AP_CTRL, got);
        check_value("ap_ctrl after done was read", got, 32'h4);
    endtask

    // issued after the first output and stalled until the block ends
    task automatic held_coef_write();
        int n;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!(sm_tvalid && sm_tready) && n < TIMEOUT);
        if (!(sm_tvalid && sm_tready)) begin
            report_timeout("the first output before the mid-run write");
        end
        axil_write(coef_addr(held_idx), held_val, RUN_TIMEOUT);
        assert (block_over) else begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time,
                                        "coefficient write accepted during a run"));
        end
    endtask

    initial begin
        int               fd;
        int               rc;
        logic [8*8-1:0]   tag;
        logic [8*128-1:0] line_buf;
        data_t            f_a;
        data_t            f_b;
        data_t            f_c;
        data_t            rd;
        axis_clk     = 1'b0;
        axis_rst_n   = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        ss_tvalid    = 1'b0;
        ss_tdata     = '0;
        ss_tlast     = 1'b0;
        sm_tready    = 1'b0;
        h0           = '0;
        block_num    = 0;
        block_over   = 1'b0;
        held_pending = 1'b0;
        held_idx     = 0;
        held_val     = '0;
        void'($urandom(SEED));
        repeat (4) @(posedge axis_clk);
        axis_rst_n <= 1'b1;
        @(posedge axis_clk);
        assert (!awready && !wready && !rvalid && arready && !ss_tready && !sm_tvalid
                && !sm_tlast) else begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time,
                                        "bus outputs not in reset state"));
        end
        axil_read(ADDR_AP_CTRL, rd);
        check_value("ap_ctrl after reset", rd, 32'h4);

        fd = $fopen("dv/fir_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open dv/fir_stimulus.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            case (tag[7:0])
                "#": begin
                    rc = $fgets(line_buf, fd);
                end
                "C": begin
                    rc = $fscanf(fd, "%h %h", f_a, f_b);
                    axil_write(coef_addr(int'(f_a)), f_b, TIMEOUT);
                    axil_read(coef_addr(int'(f_a)), rd);
                    check_value($sformatf("coefficient %0d", f_a), rd, f_b);
                    if (f_a == 0) begin
                        h0 = f_b;
                    end
                end
                "M": begin
                    rc = $fscanf(fd, "%h %h", f_a, f_b);
                    held_idx     = int'(f_a);
                    held_val     = f_b;
                    held_pending = 1'b1;
                end
                "B": begin
                    rc = $fscanf(fd, "%h", f_a);
                    x_q.delete();
                    y_q.delete();
                    for (int i = 0; i < int'(f_a); i++) begin
                        rc = $fscanf(fd, "%s %h %h", tag, f_b, f_c);
                        if (rc != 3 || tag[7:0] != "X") begin
                            stop_with_failure("stimulus file has a malformed sample line");
                        end
                        x_q.push_back(f_b);
                        y_q.push_back(f_c);
                    end
                    block_over = 1'b0;
                    fork
                        run_block(f_a);
                        if (held_pending) begin
                            held_coef_write();
                        end
                    join
                    if (held_pending) begin
                        axil_read(coef_addr(held_idx), rd);
                        check_value("coefficient after the held write", rd, held_val);
                        if (held_idx == 0) begin
                            h0 = held_val;
                        end
                        held_pending = 1'b0;
                    end
                    block_num++;
                end
                default: begin
                    stop_with_failure("stimulus file has an unknown record");
                end
            endcase
        end
        $fclose(fd);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fir_core/fir_engine.sv
`timescale 1ns/1ns
`default_nettype none

module fir_engine (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    fir_ctrl_if.engine        ctrl,
    fir_tap_if.mac            tap,
    // sample history
    output logic              ring_clear,
    output logic              ring_push,
    output fir_pkg::data_t    ring_push_data,
    output fir_pkg::tap_idx_t ring_offset,
    input  fir_pkg::data_t    ring_data,
    // input stream
    input  logic              ss_tvalid,
    input  fir_pkg::data_t    ss_tdata,
    output logic              ss_tready,
    // output stream
    output logic              sm_tvalid,
    output fir_pkg::data_t    sm_tdata,
    output logic              sm_tlast,
    input  logic              sm_tready
);
    import fir_pkg::*;

    fir_state_e state;
    tap_idx_t   tap_idx;
    // outputs handshaked in this block
    len_t       out_cnt;
    // h[k]*x[n-k], one stage ahead of the accumulator
    data_t      prod;
    logic       ss_fire;
    logic       sm_fire;
    logic       last_tap;
    logic       last_out;

    // only one sample in flight
    assign ss_tready = (state == ST_WAIT_IN);
    assign ss_fire   = ss_tvalid && ss_tready;
    assign sm_fire   = sm_tvalid && sm_tready;
    assign last_tap  = (int'(tap_idx) == NUM_TAPS - 1);
    assign last_out  = (out_cnt == ctrl.data_len - 1'b1);

    assign ring_clear     = ctrl.start && (state == ST_IDLE);
    assign ring_push      = ss_fire;
    assign ring_push_data = ss_tdata;
    // same index walks taps and history
    assign ring_offset    = tap_idx;
    assign tap.rd_idx_mac = tap_idx;

    assign ctrl.busy = (state != ST_IDLE);
    assign ctrl.done = sm_fire && sm_tlast;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= ST_IDLE;
            tap_idx   <= '0;
            out_cnt   <= '0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ctrl.start) begin
                        state   <= ST_WAIT_IN;
                        out_cnt <= '0;
                    end
                end
                ST_WAIT_IN: begin
                    if (ss_fire) begin
                        state   <= ST_MAC;
                        tap_idx <= '0;
                    end
                end
                // one tap per cycle, 0 to 10
                ST_MAC: begin
                    if (last_tap) begin
                        state <= ST_WAIT_OUT;
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                ST_WAIT_OUT: begin
                    if (!sm_tvalid) begin
                        // last product lands this cycle
                        sm_tvalid <= 1'b1;
                        sm_tlast  <= last_out;
                    end else if (sm_tready) begin
                        sm_tvalid <= 1'b0;
                        sm_tlast  <= 1'b0;
                        out_cnt   <= out_cnt + 1'b1;
                        state     <= sm_tlast ? ST_IDLE : ST_WAIT_IN;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // accumulate in the output register, wraps at 32 bits
    always_ff @(posedge axis_clk) begin
        case (state)
            ST_WAIT_IN: begin
                if (ss_fire) begin
                    prod     <= '0;
                    sm_tdata <= '0;
                end
            end
            ST_MAC: begin
                prod     <= tap.rd_data_mac * ring_data;
                sm_tdata <= sm_tdata + prod;
            end
            ST_WAIT_OUT: begin
                // held while sm_tvalid waits
                if (!sm_tvalid) begin
                    sm_tdata <= sm_tdata + prod;
                end
            end
            default: begin
                prod <= prod;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- fir_core/fir_sample_ring.sv
`timescale 1ns/1ns
`default_nettype none

module fir_sample_ring (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              clear,
    input  logic              push,
    input  fir_pkg::data_t    push_data,
    input  fir_pkg::tap_idx_t rd_offset,
    output fir_pkg::data_t    rd_data
);
    import fir_pkg::*;

    data_t      hist [NUM_TAPS];
    // next slot to write
    tap_idx_t   wr_ptr;
    logic [4:0] rd_sum;
    tap_idx_t   rd_idx;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
        end else if (push) begin
            // wrap at the tap count
            wr_ptr <= (int'(wr_ptr) == NUM_TAPS - 1) ? '0 : wr_ptr + 1'b1;
        end
    end

    // history zeroed on every start
    always_ff @(posedge axis_clk) begin
        if (clear) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (push) begin
            hist[wr_ptr] <= push_data;
        end
    end

    // newest sample sits one behind wr_ptr
    // offset k walks further back, mod NUM_TAPS
    assign rd_sum = 5'(wr_ptr) + 5'(NUM_TAPS - 1) - 5'(rd_offset);
    assign rd_idx = (int'(rd_sum) >= NUM_TAPS) ? tap_idx_t'(int'(rd_sum) - NUM_TAPS)
                                               : tap_idx_t'(rd_sum);
    assign rd_data = hist[rd_idx];

endmodule

`default_nettype wire

//--- fir_core/fir_tap_ram.sv
`timescale 1ns/1ns
`default_nettype none

module fir_tap_ram (
    input  logic   axis_clk,
    input  logic   axis_rst_n,
    fir_tap_if.ram tap
);
    import fir_pkg::*;

    data_t coef [NUM_TAPS];

    // single write port
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef[i] <= '0;
            end
        end else if (tap.wr_en && (int'(tap.wr_idx) < NUM_TAPS)) begin
            coef[tap.wr_idx] <= tap.wr_data;
        end
    end

    // combinational reads, out of range reads as zero
    assign tap.rd_data_cfg = (int'(tap.rd_idx_cfg) < NUM_TAPS) ? coef[tap.rd_idx_cfg] : '0;
    assign tap.rd_data_mac = (int'(tap.rd_idx_mac) < NUM_TAPS) ? coef[tap.rd_idx_mac] : '0;

endmodule

`default_nettype wire

//--- logic/fir_axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module fir_axil_regs (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    // write address and data, no response channel
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    output logic           awready,
    input  logic           wvalid,
    input  fir_pkg::data_t wdata,
    output logic           wready,
    // read address and data
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    output fir_pkg::data_t rdata,
    input  logic           rready,
    fir_ctrl_if.regs       ctrl,
    fir_tap_if.cfg         tap
);
    import fir_pkg::*;

    logic  ap_start;
    logic  ap_done;
    logic  ap_idle;
    len_t  data_len;
    logic  wr_allow;
    logic  wr_fire;
    logic  rd_fire;
    // ap_ctrl read returned done=1, clear on the r handshake
    logic  rd_done_seen;
    data_t ctrl_word;
    data_t rd_word;

    function automatic logic is_coef(addr_t a);
        addr_t off;
        off = a - ADDR_COEF_BASE;
        return (a >= ADDR_COEF_BASE) && (int'(off >> 2) < NUM_TAPS);
    endfunction

    function automatic tap_idx_t coef_idx(addr_t a);
        addr_t off;
        off = a - ADDR_COEF_BASE;
        return tap_idx_t'(off >> 2);
    endfunction

    // no writes from start write until the run is over
    assign wr_allow = ap_idle && !ap_start && !ctrl.busy;
    assign wr_fire  = awready && awvalid && wvalid;
    assign arready  = ~rvalid;
    assign rd_fire  = arvalid && arready;

    assign ctrl.start    = ap_start;
    assign ctrl.data_len = data_len;

    // coefficient access
    assign tap.wr_en      = wr_fire && is_coef(awaddr);
    assign tap.wr_idx     = coef_idx(awaddr);
    assign tap.wr_data    = wdata;
    assign tap.rd_idx_cfg = coef_idx(araddr);

    always_comb begin
        ctrl_word               = '0;
        ctrl_word[AP_START_BIT] = ap_start;
        ctrl_word[AP_DONE_BIT]  = ap_done;
        ctrl_word[AP_IDLE_BIT]  = ap_idle;
    end

    // read decode
    always_comb begin
        if (araddr == ADDR_AP_CTRL) begin
            rd_word = ctrl_word;
        end else if (araddr == ADDR_DATA_LEN) begin
            rd_word = data_len;
        end else if (is_coef(araddr)) begin
            rd_word = tap.rd_data_cfg;
        end else begin
            rd_word = '0;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready      <= 1'b0;
            wready       <= 1'b0;
            rvalid       <= 1'b0;
            rd_done_seen <= 1'b0;
            ap_start     <= AP_CTRL_RESET[AP_START_BIT];
            ap_done      <= AP_CTRL_RESET[AP_DONE_BIT];
            ap_idle      <= AP_CTRL_RESET[AP_IDLE_BIT];
            data_len     <= '0;
        end else begin
            // one-cycle ready pulse per write
            awready <= wr_allow && awvalid && wvalid && !awready;
            wready  <= wr_allow && awvalid && wvalid && !awready;
            if (wr_fire) begin
                if (awaddr == ADDR_AP_CTRL && wdata[AP_START_BIT]) begin
                    ap_start <= 1'b1;
                end
                if (awaddr == ADDR_DATA_LEN) begin
                    data_len <= wdata;
                end
            end
            // engine takes start the cycle after the write
            if (ap_start) begin
                ap_start <= 1'b0;
                ap_idle  <= 1'b0;
            end
            if (rd_fire) begin
                rvalid       <= 1'b1;
                rd_done_seen <= (araddr == ADDR_AP_CTRL) && ap_done;
            end else if (rvalid && rready) begin
                rvalid       <= 1'b0;
                rd_done_seen <= 1'b0;
                if (rd_done_seen) begin
                    ap_done <= 1'b0;
                end
            end
            // a new done wins over a pending clear
            if (ctrl.done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end
        end
    end

    // read data held until rready
    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

//--- logic/fir_top.sv
`timescale 1ns/1ns
`default_nettype none

module fir_top (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    // AXI-Lite
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    output logic           awready,
    input  logic           wvalid,
    input  fir_pkg::data_t wdata,
    output logic           wready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    output fir_pkg::data_t rdata,
    input  logic           rready,
    // stream in, tlast unused since data_len sets the block
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    // stream out
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    input  logic           sm_tready
);
    import fir_pkg::*;

    fir_ctrl_if ctrl_bus ();
    fir_tap_if  tap_bus ();

    // engine to history
    logic     ring_clear;
    logic     ring_push;
    data_t    ring_push_data;
    tap_idx_t ring_offset;
    data_t    ring_data;

    fir_axil_regs u_regs (.*, .ctrl(ctrl_bus), .tap(tap_bus));

    fir_tap_ram u_tap_ram (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .tap        (tap_bus)
    );

    fir_sample_ring u_ring (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .clear      (ring_clear),
        .push       (ring_push),
        .push_data  (ring_push_data),
        .rd_offset  (ring_offset),
        .rd_data    (ring_data)
    );

    fir_engine u_engine (.*, .ctrl(ctrl_bus), .tap(tap_bus));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_fir -o tb_fir \
    && ./obj_dir/tb_fir | tee /dev/stderr | grep -q "sim passed" \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

//--- sim.f
common/fir_pkg.sv
common/fir_ctrl_if.sv
common/fir_tap_if.sv
logic/fir_axil_regs.sv
fir_core/fir_tap_ram.sv
fir_core/fir_sample_ring.sv
fir_core/fir_engine.sv
logic/fir_top.sv
dv/fir_asserts.sv
dv/tb_fir.sv
